/* compile.f */
mem_acc_pkg.sv
mem_req_if.sv
req_fifo.sv
inflight_table.sv
mem_acc_scheduler.sv
mem_acc_noc_stage.sv
mem_acc_cont.sv
tb_noc_memory.sv
tb_mem_acc_cont.sv

/* inflight_table.sv */
`timescale 1ns/1ps

module inflight_table (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           log_en,       // Store a dispatched access.
    input  mem_acc_pkg::line_acc_req       log_entry,
    input  logic [mem_acc_pkg::ADDR_W-1:0] probe_addr,   // Candidate for dispatch.
    output logic                           probe_hit,
    input  logic [mem_acc_pkg::ADDR_W-1:0] reply_addr,   // Address of the returning line.
    output mem_acc_pkg::line_acc_req       reply_entry,
    output logic [mem_acc_pkg::IDX_W-1:0]  reply_index,
    input  logic                           clear_en,
    input  logic [mem_acc_pkg::IDX_W-1:0]  clear_index,
    output logic                           full
);
    mem_acc_pkg::line_acc_req              slots [mem_acc_pkg::IFR_DEPTH];
    logic [mem_acc_pkg::IFR_DEPTH-1:0]     used;          // Occupied slots.
    logic [mem_acc_pkg::IFR_DEPTH-1:0]     reply_hits;    // Per slot reply match.
    logic [mem_acc_pkg::IDX_W-1:0]         free_index;    // Lowest free slot.

    // Both compares run against every used slot.
    always_comb begin
        probe_hit   = 1'b0;
        reply_hits  = '0;
        reply_index = '0;
        free_index  = '0;
        for (int i = mem_acc_pkg::IFR_DEPTH - 1; i >= 0; i--) begin
            if (used[i] && slots[i].addr == probe_addr) probe_hit = 1'b1;
            if (used[i] && slots[i].addr == reply_addr) begin
                reply_hits[i] = 1'b1;
                reply_index   = i[mem_acc_pkg::IDX_W-1:0];
            end
            if (!used[i]) free_index = i[mem_acc_pkg::IDX_W-1:0];   // Lowest index wins.
        end
    end

    assign reply_entry = slots[reply_index];
    assign full        = &used;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            used <= '0;
        end else begin
            if (clear_en) used[clear_index] <= 1'b0;
            if (log_en) used[free_index] <= 1'b1;  // Free slot differs from the cleared one.
        end
    end

    always_ff @(posedge clk) begin
        if (log_en) slots[free_index] <= log_entry;
    end

    // Scheduler only retires a reply whose address sits in exactly one slot.
    a_reply_hit_one: assert property (@(posedge clk) disable iff (!rst_n)
        clear_en |-> $onehot(reply_hits) && reply_hits[clear_index])
        else $error("retired reply does not match exactly one in-flight entry");
endmodule

/* mem_acc_cont.sv */
`timescale 1ns/1ps

module mem_acc_cont (
    input  logic                                                       clk,
    input  logic                                                       rst_n,
    input  logic [mem_acc_pkg::NUM_PORTS-1:0]                          req_valid,
    output logic [mem_acc_pkg::NUM_PORTS-1:0]                          req_ready,
    input  logic [mem_acc_pkg::NUM_PORTS-1:0][mem_acc_pkg::ADDR_W-1:0] req_addr,
    input  logic [mem_acc_pkg::NUM_PORTS-1:0][mem_acc_pkg::LINE_W-1:0] req_data,
    input  logic [mem_acc_pkg::NUM_PORTS-1:0][mem_acc_pkg::LINE_BYTES-1:0] req_mask,
    input  logic [mem_acc_pkg::NUM_PORTS-1:0]                          req_write,
    output logic [mem_acc_pkg::NUM_PORTS-1:0]                          rsp_valid,
    input  logic [mem_acc_pkg::NUM_PORTS-1:0]                          rsp_ready,
    output logic [mem_acc_pkg::NUM_PORTS-1:0][mem_acc_pkg::ADDR_W-1:0] rsp_addr,
    output logic [mem_acc_pkg::NUM_PORTS-1:0][mem_acc_pkg::LINE_W-1:0] rsp_data,
    input  logic [mem_acc_pkg::NODE_W-1:0]                             node_addr,
    input  logic [mem_acc_pkg::NODE_W-1:0]                             node_port,
    output logic                                                       tx_valid,
    input  logic                                                       tx_ready,
    output mem_acc_pkg::noc_packet                                     tx_packet,
    input  logic                                                       rx_valid,
    output logic                                                       rx_ready,
    input  mem_acc_pkg::noc_packet                                     rx_packet
);
    mem_req_if bus ();   // Scheduler to NoC stage.

    mem_acc_scheduler u_sched (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_addr  (req_addr),
        .req_data  (req_data),
        .req_mask  (req_mask),
        .req_write (req_write),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_addr  (rsp_addr),
        .rsp_data  (rsp_data),
        .bus       (bus.sched)
    );

    mem_acc_noc_stage u_noc (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus.noc),
        .node_addr (node_addr),
        .node_port (node_port),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .tx_packet (tx_packet),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .rx_packet (rx_packet)
    );
endmodule

/* mem_acc_noc_stage.sv */
`timescale 1ns/1ps

module mem_acc_noc_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    mem_req_if.noc                         bus,
    input  logic [mem_acc_pkg::NODE_W-1:0] node_addr,   // Source fields of outgoing packets.
    input  logic [mem_acc_pkg::NODE_W-1:0] node_port,
    output logic                           tx_valid,
    input  logic                           tx_ready,
    output mem_acc_pkg::noc_packet         tx_packet,
    input  logic                           rx_valid,
    output logic                           rx_ready,
    input  mem_acc_pkg::noc_packet         rx_packet
);
    logic [mem_acc_pkg::Q_CNT_W-1:0]               rdq_count, wrq_count, rpq_count;
    logic [mem_acc_pkg::ADDR_W-1:0]                rdq_dout;
    logic [mem_acc_pkg::ADDR_W+mem_acc_pkg::LINE_W-1:0] wrq_dout;  // {addr, data}.
    mem_acc_pkg::line_read_reply                   rpq_din, rpq_dout;
    logic rdq_push, rdq_pop, wrq_push, wrq_pop, rpq_push, rpq_pop;
    logic sel_wr;     // Write queue owns tx this cycle.
    logic hold_rd;    // A read was offered and not taken.
    logic is_rply;

    assign bus.rd_open = rdq_count < mem_acc_pkg::Q_DEPTH;
    assign bus.wr_open = wrq_count < mem_acc_pkg::Q_DEPTH;
    assign rdq_push    = bus.rd_valid && bus.rd_open;
    assign wrq_push    = bus.wr_valid && bus.wr_open;

    req_fifo #(.WIDTH(mem_acc_pkg::ADDR_W), .DEPTH(mem_acc_pkg::Q_DEPTH)) u_rd_q (
        .clk(clk), .rst_n(rst_n), .push(rdq_push), .din(bus.rd_addr),
        .pop(rdq_pop), .dout(rdq_dout), .count(rdq_count)
    );

    req_fifo #(.WIDTH(mem_acc_pkg::ADDR_W + mem_acc_pkg::LINE_W),
               .DEPTH(mem_acc_pkg::Q_DEPTH)) u_wr_q (
        .clk(clk), .rst_n(rst_n), .push(wrq_push), .din({bus.wr_addr, bus.wr_data}),
        .pop(wrq_pop), .dout(wrq_dout), .count(wrq_count)
    );

    req_fifo #(.WIDTH($bits(mem_acc_pkg::line_read_reply)), .DEPTH(mem_acc_pkg::Q_DEPTH)) u_rp_q (
        .clk(clk), .rst_n(rst_n), .push(rpq_push), .din(rpq_din),
        .pop(rpq_pop), .dout(rpq_dout), .count(rpq_count)
    );

    // Packet build. Writes go first unless a stalled read must stay on the wire.
    always_comb begin
        sel_wr   = (wrq_count != '0) && !hold_rd;
        tx_valid = (wrq_count != '0) || (rdq_count != '0);
        tx_packet.hdr.dst_addr = mem_acc_pkg::MEM_NOC_ADDR;
        tx_packet.hdr.dst_port = mem_acc_pkg::MEM_NOC_PORT;
        tx_packet.hdr.src_addr = node_addr;
        tx_packet.hdr.src_port = node_port;
        tx_packet.pld          = '0;
        if (sel_wr) begin
            tx_packet.hdr.len      = mem_acc_pkg::PKT_LEN_WR;
            tx_packet.pld.wr_rq.pt = mem_acc_pkg::memory_write_request;
            tx_packet.pld.wr_rq.dat  = wrq_dout[mem_acc_pkg::LINE_W-1:0];
            tx_packet.pld.wr_rq.addr = wrq_dout[mem_acc_pkg::ADDR_W+mem_acc_pkg::LINE_W-1 -:
                                                mem_acc_pkg::ADDR_W];
        end else begin
            tx_packet.hdr.len        = mem_acc_pkg::PKT_LEN_RD;
            tx_packet.pld.rd_rq.pt   = mem_acc_pkg::memory_read_request;
            tx_packet.pld.rd_rq.addr = rdq_dout;
        end
    end

    assign wrq_pop = tx_valid && tx_ready && sel_wr;
    assign rdq_pop = tx_valid && tx_ready && !sel_wr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_rd <= 1'b0;
        end else begin
            hold_rd <= tx_valid && !tx_ready && !sel_wr;
        end
    end

    // Reply parse. Anything but a read reply is taken and dropped.
    assign is_rply  = rx_packet.pld.rd_rply.pt == mem_acc_pkg::memory_read_reply;
    assign rx_ready = rx_valid && (!is_rply || rpq_count < mem_acc_pkg::Q_DEPTH);
    assign rpq_push = rx_ready && is_rply;
    assign rpq_din.addr = rx_packet.pld.rd_rply.addr;
    assign rpq_din.dat  = rx_packet.pld.rd_rply.dat;

    assign bus.rpl_valid = rpq_count != '0;
    assign bus.rpl_addr  = rpq_dout.addr;
    assign bus.rpl_data  = rpq_dout.dat;
    assign rpq_pop       = bus.rpl_valid && bus.rpl_accept;

    a_tx_stable: assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_packet))
        else $error("tx packet changed while waiting for tx_ready");
endmodule

/* mem_acc_pkg.sv */
package mem_acc_pkg;

    localparam int ADDR_W     = 32;                     // Line address width.
    localparam int LINE_W     = 128;                    // One cache line.
    localparam int LINE_BYTES = 16;                     // Bytes per line, also mask width.
    localparam int NUM_PORTS  = 2;                      // Front-end ports.
    localparam int PRT_W      = $clog2(NUM_PORTS);
    localparam int IFR_DEPTH  = 8;                      // In-flight table entries.
    localparam int IDX_W      = $clog2(IFR_DEPTH);
    localparam int Q_DEPTH    = 4;                      // Every NoC stage queue.
    localparam int Q_CNT_W    = $clog2(Q_DEPTH + 1);    // Queue occupancy counter.

    // NoC addressing of the memory node.
    localparam int NODE_W = 4;
    localparam logic [NODE_W-1:0] MEM_NOC_ADDR = 4'h1;
    localparam logic [NODE_W-1:0] MEM_NOC_PORT = 4'h0;

    typedef enum logic [7:0] {
        memory_read_request  = 8'd1,
        memory_write_request = 8'd2,
        memory_read_reply    = 8'd3
    } pkt_type_t;

    // Access as logged in the in-flight table.
    typedef struct packed {
        logic [ADDR_W-1:0]     addr;
        logic [LINE_W-1:0]     dat;
        logic [LINE_BYTES-1:0] wmsk;    // Byte enables of a write.
        logic                  rqt;     // 1 for a write.
        logic [PRT_W-1:0]      prt;     // Issuing port.
    } line_acc_req;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LINE_W-1:0] dat;
    } line_read_reply;

    typedef struct packed {
        logic [NODE_W-1:0] dst_addr;
        logic [NODE_W-1:0] dst_port;
        logic [NODE_W-1:0] src_addr;
        logic [NODE_W-1:0] src_port;
        logic [7:0]        len;         // Header plus payload in bytes.
    } noc_header;

    // Type code always sits in the low byte.
    typedef struct packed {
        logic [LINE_W-1:0] pad;
        logic [ADDR_W-1:0] addr;
        pkt_type_t         pt;
    } mem_rd_rq;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LINE_W-1:0] dat;
        pkt_type_t         pt;
    } mem_wr_rq;

    typedef mem_wr_rq mem_rd_rply;     // Reply shares the write layout.

    typedef union packed {
        mem_rd_rq   rd_rq;
        mem_wr_rq   wr_rq;
        mem_rd_rply rd_rply;
    } noc_payload;

    typedef struct packed {
        noc_header  hdr;
        noc_payload pld;
    } noc_packet;

    // A read request carries only the type code and the address.
    localparam logic [7:0] PKT_LEN_RD = 8'(($bits(noc_header) + ADDR_W + 8) / 8);
    localparam logic [7:0] PKT_LEN_WR = 8'(($bits(noc_header) + $bits(mem_wr_rq)) / 8);

endpackage

/* mem_acc_scheduler.sv */
`timescale 1ns/1ps

module mem_acc_scheduler (
    input  logic                                                       clk,
    input  logic                                                       rst_n,
    input  logic [mem_acc_pkg::NUM_PORTS-1:0]                          req_valid,
    output logic [mem_acc_pkg::NUM_PORTS-1:0]                          req_ready,
    input  logic [mem_acc_pkg::NUM_PORTS-1:0][mem_acc_pkg::ADDR_W-1:0] req_addr,
    input  logic [mem_acc_pkg::NUM_PORTS-1:0][mem_acc_pkg::LINE_W-1:0] req_data,
    input  logic [mem_acc_pkg::NUM_PORTS-1:0][mem_acc_pkg::LINE_BYTES-1:0] req_mask,
    input  logic [mem_acc_pkg::NUM_PORTS-1:0]                          req_write,
    output logic [mem_acc_pkg::NUM_PORTS-1:0]                          rsp_valid,
    input  logic [mem_acc_pkg::NUM_PORTS-1:0]                          rsp_ready,
    output logic [mem_acc_pkg::NUM_PORTS-1:0][mem_acc_pkg::ADDR_W-1:0] rsp_addr,
    output logic [mem_acc_pkg::NUM_PORTS-1:0][mem_acc_pkg::LINE_W-1:0] rsp_data,
    mem_req_if.sched                                                   bus
);
    logic [mem_acc_pkg::PRT_W-1:0]  sel;          // Port chosen for dispatch.
    logic                           found;        // Some port is presenting.
    logic                           probe_hit;    // Chosen address already in flight.
    logic                           table_full;
    logic                           dispatch;
    mem_acc_pkg::line_acc_req       log_entry;
    mem_acc_pkg::line_acc_req       reply_entry;  // Parent of the returning line.
    logic [mem_acc_pkg::IDX_W-1:0]  reply_index;
    logic [mem_acc_pkg::LINE_W-1:0] merged;       // Write bytes over the returned line.
    logic                           retire;

    inflight_table u_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .log_en      (dispatch),
        .log_entry   (log_entry),
        .probe_addr  (req_addr[sel]),
        .probe_hit   (probe_hit),
        .reply_addr  (bus.rpl_addr),
        .reply_entry (reply_entry),
        .reply_index (reply_index),
        .clear_en    (retire),
        .clear_index (reply_index),
        .full        (table_full)
    );

    // Dispatch. Lowest presenting port is probed and goes if it is free to.
    always_comb begin
        sel   = '0;
        found = 1'b0;
        for (int i = mem_acc_pkg::NUM_PORTS - 1; i >= 0; i--) begin
            if (req_valid[i]) begin
                sel   = i[mem_acc_pkg::PRT_W-1:0];
                found = 1'b1;
            end
        end
        dispatch       = found && !probe_hit && !table_full && bus.rd_open;
        req_ready      = '0;
        req_ready[sel] = dispatch;

        log_entry.addr = req_addr[sel];
        log_entry.dat  = req_data[sel];
        log_entry.wmsk = req_mask[sel];
        log_entry.rqt  = req_write[sel];
        log_entry.prt  = sel;                          // Remember who gets the answer.

        bus.rd_valid = dispatch;                       // Every access starts with a line read.
        bus.rd_addr  = req_addr[sel];
    end

    // Retirement of the reply at the head of the reply queue.
    always_comb begin
        for (int b = 0; b < mem_acc_pkg::LINE_BYTES; b++) begin
            merged[b*8 +: 8] = reply_entry.wmsk[b] ? reply_entry.dat[b*8 +: 8]
                                                   : bus.rpl_data[b*8 +: 8];
        end
        for (int p = 0; p < mem_acc_pkg::NUM_PORTS; p++) begin
            rsp_addr[p] = bus.rpl_addr;
            rsp_data[p] = bus.rpl_data;
        end
        rsp_valid    = '0;
        bus.wr_valid = 1'b0;
        bus.wr_addr  = reply_entry.addr;
        bus.wr_data  = merged;
        retire       = 1'b0;
        if (bus.rpl_valid) begin
            if (reply_entry.rqt) begin
                bus.wr_valid = 1'b1;                   // Merged line goes back to memory.
                retire       = bus.wr_open;
            end else begin
                rsp_valid[reply_entry.prt] = 1'b1;
                retire = rsp_ready[reply_entry.prt];
            end
        end
        bus.rpl_accept = retire;                       // Entry clears on the same edge.
    end
endmodule

/* mem_req_if.sv */
`timescale 1ns/1ps

interface mem_req_if;
    // Read requests toward memory.
    logic                           rd_valid;
    logic [mem_acc_pkg::ADDR_W-1:0] rd_addr;
    logic                           rd_open;

    // Merged writes toward memory.
    logic                           wr_valid;
    logic [mem_acc_pkg::ADDR_W-1:0] wr_addr;
    logic [mem_acc_pkg::LINE_W-1:0] wr_data;
    logic                           wr_open;

    // Read replies back from memory.
    logic                           rpl_valid;
    logic [mem_acc_pkg::ADDR_W-1:0] rpl_addr;
    logic [mem_acc_pkg::LINE_W-1:0] rpl_data;
    logic                           rpl_accept;

    modport sched (
        output rd_valid, rd_addr,
        input  rd_open,
        output wr_valid, wr_addr, wr_data,
        input  wr_open,
        input  rpl_valid, rpl_addr, rpl_data,
        output rpl_accept
    );

    modport noc (
        input  rd_valid, rd_addr,
        output rd_open,
        input  wr_valid, wr_addr, wr_data,
        output wr_open,
        output rpl_valid, rpl_addr, rpl_data,
        input  rpl_accept
    );
endinterface

/* req_fifo.sv */
`timescale 1ns/1ps

module req_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  logic [WIDTH-1:0]           din,
    input  logic                       pop,
    output logic [WIDTH-1:0]           dout,    // Head entry.
    output logic [$clog2(DEPTH+1)-1:0] count
);
    logic [WIDTH-1:0]         mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] head;            // Oldest entry.
    logic [$clog2(DEPTH)-1:0] tail;            // Next free slot.

    assign dout = mem[head];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) tail <= (tail == DEPTH-1) ? '0 : tail + 1'b1;
            if (pop) head <= (head == DEPTH-1) ? '0 : head + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                     // Both or neither leave the count.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[tail] <= din;
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> count < DEPTH)
        else $error("push into a full queue");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> count != '0)
        else $error("pop from an empty queue");
endmodule

/* tb_mem_acc_cont.sv */
`timescale 1ns/1ps

module tb_mem_acc_cont;
    localparam int          NP        = mem_acc_pkg::NUM_PORTS;
    localparam int          CLK_HALF  = 10;
    localparam int          N_TRANS   = 321;              // Accesses over all tests.
    localparam logic [31:0] SEED      = 32'h213c55c6;
    localparam logic [31:0] ADDR_BASE = 32'h1c40_2200;    // 16 lines from here.
    localparam logic [7:0]  RD_LEN    = 8'd3 + 8'd1 + 8'd4;           // Header, type, address.
    localparam logic [7:0]  WR_LEN    = 8'd3 + 8'd1 + 8'd16 + 8'd4;   // Plus the line.

    typedef struct packed {
        logic [mem_acc_pkg::PRT_W-1:0] prt;
        logic                          wr;
        logic [31:0]                   addr;
        logic [127:0]                  dat;
        logic [15:0]                   msk;
    } access_t;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic [NP-1:0]          req_valid, req_ready, req_write, rsp_valid, rsp_ready;
    logic [NP-1:0][31:0]    req_addr, rsp_addr;
    logic [NP-1:0][127:0]   req_data, rsp_data;
    logic [NP-1:0][15:0]    req_mask;
    logic [3:0]             node_addr, node_port;
    logic                   tx_valid, tx_ready, rx_valid, rx_ready;
    mem_acc_pkg::noc_packet tx_packet, rx_packet;

    integer        seed = SEED;
    access_t       stim [$];        // Requests not yet presented.
    access_t       pend [$];        // Accepted reads with their expected line.
    access_t       cur [NP];        // Request on each port.
    logic [NP-1:0] busy;
    logic [127:0]  shadow [16];     // Memory after every accepted request.
    logic [127:0]  last_rsp;
    logic          rand_ready;
    string         test_name;
    int writes_acc, writes_sent, test_errs, errors, checks, tests, failed;

    mem_acc_cont dut (.*);

    tb_noc_memory #(.SEED(SEED)) u_mem (.*);

    always #CLK_HALF clk = ~clk;

    task automatic check(input string what, input logic [159:0] exp, input logic [159:0] act);
        checks++;
        if (exp !== act) begin
            test_errs++;
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic report(input string msg);
        test_errs++;
        $display("%s: %s", test_name, msg);
    endtask

    function automatic logic [127:0] init_line(input int idx);
        logic [31:0] a;
        a = ADDR_BASE + idx;
        return {4{a}};     // Address repeated four times.
    endfunction

    // Masked bytes come from the write, the rest from the old line.
    function automatic logic [127:0] merge_line(input logic [127:0] old,
                                                input logic [127:0] dat, input logic [15:0] msk);
        for (int b = 0; b < 16; b++) begin
            if (msk[b]) old[b*8 +: 8] = dat[b*8 +: 8];
        end
        return old;
    endfunction

    task automatic push(input int prt, input logic wr, input int idx,
                        input logic [127:0] dat, input logic [15:0] msk);
        access_t a;
        a.prt  = prt;
        a.wr   = wr;
        a.addr = ADDR_BASE + idx;
        a.dat  = dat;
        a.msk  = msk;
        stim.push_back(a);
    endtask

    // One clock: drive at the falling edge, sample handshakes at the rising edge.
    task automatic cycle;
        int      k;
        logic    waiting;
        access_t e;
        @(negedge clk);
        for (int p = 0; p < NP; p++) begin
            waiting = 1'b0;
            foreach (pend[j]) begin
                if (pend[j].prt == p) waiting = 1'b1;   // One read per port in flight.
            end
            if (!busy[p] && !waiting) begin
                k = -1;
                foreach (stim[j]) begin
                    if (k < 0 && stim[j].prt == p) k = j;
                end
                if (k >= 0) begin
                    cur[p]  = stim[k];
                    busy[p] = 1'b1;
                    stim.delete(k);
                end
            end
            req_valid[p] = busy[p];
            req_write[p] = cur[p].wr;
            req_addr[p]  = cur[p].addr;
            req_data[p]  = cur[p].dat;
            req_mask[p]  = cur[p].msk;
            rsp_ready[p] = !rand_ready || ($random(seed) % 4 != 0);
        end
        tx_ready = !rand_ready || ($random(seed) % 4 != 0);
        @(posedge clk);
        for (int p = 0; p < NP; p++) begin
            if (req_valid[p] && req_ready[p]) begin
                busy[p] = 1'b0;
                e       = cur[p];
                if (e.wr) begin
                    shadow[e.addr[3:0]] = merge_line(shadow[e.addr[3:0]], e.dat, e.msk);
                    writes_acc++;
                end else begin
                    e.dat = shadow[e.addr[3:0]];   // Line as it stands at acceptance.
                    pend.push_back(e);
                end
            end
            if (rsp_valid[p] && rsp_ready[p]) begin
                k = -1;
                foreach (pend[j]) begin
                    if (k < 0 && pend[j].prt == p) k = j;
                end
                last_rsp = rsp_data[p];
                if (k < 0) begin
                    report($sformatf("response on port %0d with no read outstanding", p));
                end else begin
                    check("rsp_addr", pend[k].addr, rsp_addr[p]);
                    check("rsp_data", pend[k].dat, rsp_data[p]);
                    pend.delete(k);
                end
            end
        end
        if (tx_valid && tx_ready) begin
            check("dst_addr", mem_acc_pkg::MEM_NOC_ADDR, tx_packet.hdr.dst_addr);
            check("dst_port", mem_acc_pkg::MEM_NOC_PORT, tx_packet.hdr.dst_port);
            check("src_addr", node_addr, tx_packet.hdr.src_addr);
            check("src_port", node_port, tx_packet.hdr.src_port);
            case (8'(tx_packet.pld.rd_rq.pt))
                8'd1: check("read len", RD_LEN, tx_packet.hdr.len);
                8'd2: begin
                    check("write len", WR_LEN, tx_packet.hdr.len);
                    writes_sent++;
                end
                default: report("tx packet carries an unknown type code");
            endcase
        end
    endtask

    // Runs until every request is answered and every write has left on tx.
    task automatic drain;
        while (stim.size() != 0 || busy != '0 || pend.size() != 0 || writes_sent != writes_acc)
            cycle();
    endtask

    task automatic close_test;
        tests++;
        errors += test_errs;
        if (test_errs != 0) failed++;
        $display("%-12s %s (%0d problems)", test_name, test_errs == 0 ? "passed" : "failed",
                 test_errs);
        test_errs = 0;
    endtask

    initial begin
        logic [127:0] d;
        logic [15:0]  m;
        rst_n      = 1'b0;
        req_valid  = '0;
        req_write  = '0;
        req_addr   = '0;
        req_data   = '0;
        req_mask   = '0;
        rsp_ready  = '0;
        tx_ready   = 1'b0;
        node_addr  = 4'h6;
        node_port  = 4'h2;
        busy       = '0;
        rand_ready = 1'b0;
        for (int p = 0; p < NP; p++) cur[p] = '0;
        {writes_acc, writes_sent, test_errs, errors, checks, tests, failed} = '0;
        for (int i = 0; i < 16; i++) shadow[i] = init_line(i);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_name = "reset";
        @(posedge clk);
        check("tx_valid", 0, tx_valid);
        check("rsp_valid", 0, rsp_valid);
        check("rx_ready", 0, rx_ready);
        close_test();

        test_name = "single_read";
        push(1, 1'b0, 3, '0, '0);
        drain();
        check("line", init_line(3), last_rsp);
        close_test();

        test_name = "write_read";
        d = {$random(seed), $random(seed), $random(seed), $random(seed)};
        m = 16'h0f3c;
        push(0, 1'b1, 5, d, m);
        push(0, 1'b0, 5, '0, '0);
        drain();
        check("merged", merge_line(init_line(5), d, m), last_rsp);
        close_test();

        test_name = "same_cycle";      // Port 0 wins, the read waits on the conflict.
        d = {$random(seed), $random(seed), $random(seed), $random(seed)};
        m = 16'($random(seed));
        push(0, 1'b1, 9, d, m);
        push(1, 1'b0, 9, '0, '0);
        drain();
        check("merged", merge_line(init_line(9), d, m), last_rsp);
        close_test();

        test_name  = "random";
        rand_ready = 1'b1;
        repeat (300) begin
            d = {$random(seed), $random(seed), $random(seed), $random(seed)};
            push($unsigned($random(seed)) % NP, $random(seed) % 2 != 0,
                 $unsigned($random(seed)) % 16, d, 16'($random(seed)));
        end
        drain();
        // Read every line back so the last writes reach a compare.
        for (int i = 0; i < 16; i++) push(i % NP, 1'b0, i, '0, '0);
        drain();
        close_test();

        $display("tests %0d, failed %0d, checks %0d, problems %0d", tests, failed, checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        #(N_TRANS * 200 * 2 * CLK_HALF);
        $display("Timeout: the run did not finish within %0d cycles", N_TRANS * 200);
        $display("ERRORS FOUND");
        $finish;
    end
endmodule

/* tb_noc_memory.sv */
`timescale 1ns/1ps

module tb_noc_memory #(
    parameter logic [31:0] SEED = 32'h1
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   tx_valid,
    input  logic                   tx_ready,
    input  mem_acc_pkg::noc_packet tx_packet,
    output logic                   rx_valid,
    output mem_acc_pkg::noc_packet rx_packet,
    input  logic                   rx_ready
);
    logic [127:0]           lines [256];   // Indexed by the low address byte.
    logic [255:0]           written;       // Lines that a write has touched.
    mem_acc_pkg::noc_packet replies [$];   // Answers in packet order.
    int                     due [$];       // First cycle each answer may go out.
    int                     now;
    integer                 seed;

    // Untouched lines hold their address four times over.
    function automatic logic [127:0] line_at(input logic [31:0] addr);
        return written[addr[7:0]] ? lines[addr[7:0]] : {4{addr}};
    endfunction

    task automatic take_packet;
        mem_acc_pkg::noc_packet rply;
        case (tx_packet.pld.rd_rq.pt)
            mem_acc_pkg::memory_read_request: begin
                rply = '0;
                rply.hdr.dst_addr     = tx_packet.hdr.src_addr;   // Back to the sender.
                rply.hdr.dst_port     = tx_packet.hdr.src_port;
                rply.hdr.src_addr     = mem_acc_pkg::MEM_NOC_ADDR;
                rply.hdr.src_port     = mem_acc_pkg::MEM_NOC_PORT;
                rply.hdr.len          = 8'd24;
                rply.pld.rd_rply.pt   = mem_acc_pkg::memory_read_reply;
                rply.pld.rd_rply.addr = tx_packet.pld.rd_rq.addr;
                rply.pld.rd_rply.dat  = line_at(tx_packet.pld.rd_rq.addr);
                replies.push_back(rply);
                due.push_back(now + $unsigned($random(seed)) % 8);   // 0 to 7 cycles.
            end
            mem_acc_pkg::memory_write_request: begin
                lines[tx_packet.pld.wr_rq.addr[7:0]]   = tx_packet.pld.wr_rq.dat;
                written[tx_packet.pld.wr_rq.addr[7:0]] = 1'b1;
            end
            default: ;
        endcase
    endtask

    initial begin
        seed      = SEED;
        written   = '0;
        now       = 0;
        rx_valid  = 1'b0;
        rx_packet = '0;
        forever begin
            @(posedge clk);
            if (rst_n) begin
                now++;
                if (rx_valid && rx_ready) begin
                    replies.delete(0);   // Head answer taken.
                    due.delete(0);
                end
                if (tx_valid && tx_ready) take_packet();
            end
            @(negedge clk);
            rx_valid = 1'b0;
            if (replies.size() != 0) begin
                rx_valid  = now >= due[0];
                rx_packet = replies[0];
            end
        end
    end
endmodule
